// ==== rtl/tetris_pkg.sv ====
// field dimensions, shape codes, shape footprints, controller state type
`default_nettype none

package tetris_pkg;

	localparam int field_w = 6;  // columns
	localparam int ceil_h  = 3;  // spare rows above the playable area

	typedef logic [2:0] col_t;

	typedef enum logic [2:0] {
		sq     = 3'd0,
		line_v = 3'd1,
		line_h = 3'd2,
		l_inv  = 3'd3,
		l_hori = 3'd4,
		l_norm = 3'd5,
		s_vert = 3'd6,
		s_norm = 3'd7
	} shape_t;

	typedef enum logic [1:0] {
		idle   = 2'd0,
		drop   = 2'd1,
		clear  = 2'd2,
		report = 2'd3
	} ctrl_state_t;

	// 4x4 grid, bit row*4+col, row 0 is the bottom of the piece
	function automatic logic [15:0] shape_mask(input shape_t shape);
		logic [15:0] mask;
		case (shape)
			sq:      mask = 16'h0033;
			line_v:  mask = 16'h1111;
			line_h:  mask = 16'h000f;
			l_inv:   mask = 16'h0322;  // hook at the top left
			l_hori:  mask = 16'h0071;
			l_norm:  mask = 16'h0113;  // foot at the bottom right
			s_vert:  mask = 16'h0132;
			s_norm:  mask = 16'h0063;
			default: mask = 16'h0000;
		endcase
		return mask;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/drop_solver.sv ====
// shape footprint lookup, parallel landing row search, placement vector
`default_nettype none

module drop_solver #(
	parameter int  FIELD_H = 12,
	localparam int FW      = tetris_pkg::field_w,
	localparam int ROWS    = FIELD_H + tetris_pkg::ceil_h + 1,
	localparam int CELL_W  = FW * ROWS
) (
	input  tetris_pkg::shape_t piece_shape_i,
	input  tetris_pkg::col_t   piece_col_i,
	input  logic [CELL_W-1:0]  field_cells_i,
	output logic [4:0]         land_row_o,
	output logic [CELL_W-1:0]  place_cells_o
);

	// one test per candidate bottom row, ground row included
	localparam int NTEST = FIELD_H + tetris_pkg::ceil_h;

	logic [15:0]          mask;
	logic [FW-1:0]        piece_row [4];  // footprint rows moved to the piece column
	logic [CELL_W+3*FW-1:0] ext_cells;    // field with empty rows above the top
	logic [CELL_W-1:0]    piece_flat;
	logic [NTEST-1:0]     hit;

	// --------------------------------------------------
	// footprint
	// --------------------------------------------------
	assign mask = tetris_pkg::shape_mask(piece_shape_i);

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			piece_row[k] = FW'(mask[k*4 +: 4]) << piece_col_i;
		end
	end

	assign piece_flat = CELL_W'({piece_row[3], piece_row[2], piece_row[1], piece_row[0]});

	// --------------------------------------------------
	// overlap tests, all heights at once
	// --------------------------------------------------
	assign ext_cells = {{(3*FW){1'b0}}, field_cells_i};

	for (genvar r = 0; r < NTEST; r++) begin : g_test
		logic [FW-1:0] clash;

		always_comb begin
			clash = '0;
			for (int k = 0; k < 4; k++) begin
				clash = clash | (piece_row[k] & ext_cells[(r+k)*FW +: FW]);
			end
		end

		assign hit[r] = |clash;
	end

	// highest colliding height wins, piece rests one row above it
	always_comb begin
		land_row_o = 5'd0;
		for (int r = 0; r < NTEST; r++) begin
			if (hit[r]) begin
				land_row_o = 5'(r + 1);
			end
		end
	end

	// cells pushed past the top row fall off the vector
	assign place_cells_o = piece_flat << (land_row_o * FW);

endmodule

`default_nettype wire

// ==== rtl/playfield.sv ====
// field storage, placement, row clearing, full row and ceiling detection, dump
`default_nettype none

module playfield #(
	parameter int  FIELD_H = 12,
	localparam int FW      = tetris_pkg::field_w,
	localparam int TOP     = FIELD_H + tetris_pkg::ceil_h,  // highest stored row
	localparam int CELL_W  = FW * (TOP + 1),
	localparam int DUMP_W  = FW * FIELD_H
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              place_en_i,
	input  logic [CELL_W-1:0] place_cells_i,
	input  logic              clear_en_i,
	input  logic              wipe_en_i,
	output logic [CELL_W-1:0] field_cells_o,
	output logic              rows_full_o,
	output logic              over_ceiling_o,
	output logic [DUMP_W-1:0] tetris_o
);

	// rows 1..TOP, row 1 in the low bits; ground row is not stored
	logic [TOP*FW-1:0] field_q;
	logic [TOP*FW-1:0] field_down;  // every row moved down by one
	logic [TOP*FW-1:0] shift_sel;   // rows at or above the lowest full row
	logic [TOP*FW-1:0] field_clr;
	logic [TOP:1]      full;

	// --------------------------------------------------
	// full rows and clear shift
	// --------------------------------------------------
	always_comb begin
		logic row_seen;
		row_seen = 1'b0;
		for (int i = 1; i <= TOP; i++) begin
			full[i]  = (i <= FIELD_H) && (&field_q[(i-1)*FW +: FW]);
			row_seen = row_seen | full[i];
			shift_sel[(i-1)*FW +: FW] = {FW{row_seen}};
		end
	end

	assign field_down = {{FW{1'b0}}, field_q[TOP*FW-1:FW]};

	// only the lowest full row goes per cycle
	assign field_clr = (field_q & ~shift_sel) | (field_down & shift_sel);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field_q <= '0;
		end
		else if (wipe_en_i) begin
			field_q <= '0;  // new game
		end
		else if (place_en_i) begin
			field_q <= field_q | place_cells_i[CELL_W-1:FW];
		end
		else if (clear_en_i) begin
			field_q <= field_clr;
		end
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	assign field_cells_o  = {field_q, {FW{1'b1}}};  // ground row always full
	assign rows_full_o    = |full;
	assign over_ceiling_o = |field_q[FIELD_H*FW +: FW];  // row FIELD_H+1
	assign tetris_o       = wipe_en_i ? field_q[DUMP_W-1:0] : '0;

endmodule

`default_nettype wire

// ==== rtl/game_ctrl.sv ====
// round FSM, piece input registers, piece counter, score and report strobes
`default_nettype none

module game_ctrl #(
	parameter int  GAME_ROUNDS = 16,
	localparam int RND_W       = (GAME_ROUNDS > 1) ? $clog2(GAME_ROUNDS) : 1
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid_i,
	input  tetris_pkg::shape_t tetromino_i,
	input  tetris_pkg::col_t   position_i,
	input  logic               rows_full_i,
	input  logic               over_ceiling_i,
	output tetris_pkg::shape_t piece_shape_o,
	output tetris_pkg::col_t   piece_col_o,
	output logic               place_en_o,
	output logic               clear_en_o,
	output logic               wipe_en_o,
	output logic               score_valid_o,
	output logic               fail_o,
	output logic               tetris_valid_o,
	output logic [3:0]         score_o
);

	tetris_pkg::ctrl_state_t state_q, state_d;

	logic [RND_W-1:0] round_q;  // pieces done in this game
	logic [3:0]       score_q;
	logic             in_report;
	logic             game_end;

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			tetris_pkg::idle: begin
				if (in_valid_i) begin
					state_d = tetris_pkg::drop;
				end
			end
			tetris_pkg::drop:   state_d = tetris_pkg::clear;
			tetris_pkg::clear: begin
				if (!rows_full_i) begin
					state_d = tetris_pkg::report;
				end
			end
			default: state_d = tetris_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= tetris_pkg::idle;
		end
		else begin
			state_q <= state_d;
		end
	end

	// piece latched only when a round starts
	always_ff @(posedge clk) begin
		if (state_q == tetris_pkg::idle && in_valid_i) begin
			piece_shape_o <= tetromino_i;
			piece_col_o   <= position_i;
		end
	end

	// --------------------------------------------------
	// piece counter and score
	// --------------------------------------------------
	assign in_report = (state_q == tetris_pkg::report);
	assign game_end  = in_report && (over_ceiling_i || round_q == RND_W'(GAME_ROUNDS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_q <= '0;
			score_q <= '0;
		end
		else if (game_end) begin
			round_q <= '0;
			score_q <= '0;
		end
		else begin
			if (in_report) begin
				round_q <= round_q + 1'b1;
			end
			if (clear_en_o && rows_full_i) begin
				score_q <= score_q + 4'd1;  // one per removed row
			end
		end
	end

	assign place_en_o     = (state_q == tetris_pkg::drop);
	assign clear_en_o     = (state_q == tetris_pkg::clear);
	assign wipe_en_o      = game_end;
	assign score_valid_o  = in_report;
	assign fail_o         = in_report && over_ceiling_i;
	assign tetris_valid_o = game_end;
	assign score_o        = in_report ? score_q : 4'd0;

endmodule

`default_nettype wire

// ==== rtl/tetris_top.sv ====
// top level joining controller, drop solver and playfield
`default_nettype none

module tetris_top #(
	parameter int  FIELD_H     = 12,
	parameter int  GAME_ROUNDS = 16,
	localparam int CELL_W      = tetris_pkg::field_w * (FIELD_H + tetris_pkg::ceil_h + 1),
	localparam int DUMP_W      = tetris_pkg::field_w * FIELD_H
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid_i,
	input  tetris_pkg::shape_t tetromino_i,
	input  tetris_pkg::col_t   position_i,
	output logic               score_valid_o,
	output logic               fail_o,
	output logic               tetris_valid_o,
	output logic [3:0]         score_o,
	output logic [DUMP_W-1:0]  tetris_o
);

	tetris_pkg::shape_t piece_shape;
	tetris_pkg::col_t   piece_col;

	logic              place_en;
	logic              clear_en;
	logic              wipe_en;
	logic              rows_full;
	logic              over_ceiling;
	logic [CELL_W-1:0] field_cells;
	logic [CELL_W-1:0] place_cells;

	game_ctrl #(
		.GAME_ROUNDS (GAME_ROUNDS)
	) u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid_i     (in_valid_i),
		.tetromino_i    (tetromino_i),
		.position_i     (position_i),
		.rows_full_i    (rows_full),
		.over_ceiling_i (over_ceiling),
		.piece_shape_o  (piece_shape),
		.piece_col_o    (piece_col),
		.place_en_o     (place_en),
		.clear_en_o     (clear_en),
		.wipe_en_o      (wipe_en),
		.score_valid_o  (score_valid_o),
		.fail_o         (fail_o),
		.tetris_valid_o (tetris_valid_o),
		.score_o        (score_o)
	);

	drop_solver #(
		.FIELD_H (FIELD_H)
	) u_solver (
		.piece_shape_i (piece_shape),
		.piece_col_i   (piece_col),
		.field_cells_i (field_cells),
		.land_row_o    (),
		.place_cells_o (place_cells)
	);

	playfield #(
		.FIELD_H (FIELD_H)
	) u_field (
		.clk            (clk),
		.rst_n          (rst_n),
		.place_en_i     (place_en),
		.place_cells_i  (place_cells),
		.clear_en_i     (clear_en),
		.wipe_en_i      (wipe_en),
		.field_cells_o  (field_cells),
		.rows_full_o    (rows_full),
		.over_ceiling_o (over_ceiling),
		.tetris_o       (tetris_o)
	);

endmodule

`default_nettype wire

// ==== sim/tetris_sva.sv ====
// bound assertions on the report strobes and output gating of tetris_top
`default_nettype none

module tetris_sva #(
	parameter int DUMP_W = 72
) (
	input logic              clk,
	input logic              rst_n,
	input logic              score_valid_o,
	input logic              fail_o,
	input logic              tetris_valid_o,
	input logic [3:0]        score_o,
	input logic [DUMP_W-1:0] tetris_o
);

	timeunit 1ns;
	timeprecision 1ns;

	int err_cnt = 0;

	task automatic flag_failure(input string what);
		err_cnt++;
		$error("%s", what);
	endtask

	a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		score_valid_o |=> !score_valid_o)
		else flag_failure("score_valid_o held for more than one cycle");

	a_end_in_report: assert property (@(posedge clk) disable iff (!rst_n)
		tetris_valid_o |-> score_valid_o)
		else flag_failure("tetris_valid_o outside a report cycle");

	a_fail_ends: assert property (@(posedge clk) disable iff (!rst_n)
		fail_o |-> tetris_valid_o)
		else flag_failure("fail_o without a game end");

	// score and fail are zero between reports
	a_quiet_score: assert property (@(posedge clk) disable iff (!rst_n)
		!score_valid_o |-> (score_o == 4'd0 && !fail_o))
		else flag_failure("score_o or fail_o set outside a report cycle");

	a_quiet_dump: assert property (@(posedge clk) disable iff (!rst_n)
		!tetris_valid_o |-> (tetris_o == '0))
		else flag_failure("tetris_o not zero outside a game end");

endmodule

bind tetris_top tetris_sva #(
	.DUMP_W (DUMP_W)
) u_sva (
	.clk            (clk),
	.rst_n          (rst_n),
	.score_valid_o  (score_valid_o),
	.fail_o         (fail_o),
	.tetris_valid_o (tetris_valid_o),
	.score_o        (score_o),
	.tetris_o       (tetris_o)
);

`default_nettype wire

// ==== sim/tetris_tb.sv ====
// testbench for tetris_top with LFSR pieces, reference field model and report checks
`default_nettype none

module tetris_tb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int FIELD_H = 12;
	localparam int ROUNDS  = 16;
	localparam int TOP     = FIELD_H + tetris_pkg::ceil_h;  // highest stored row

	typedef logic [6*FIELD_H-1:0] dump_t;

	logic               clk;
	logic               rst_n;
	logic               in_valid_i;
	tetris_pkg::shape_t tetromino_i;
	tetris_pkg::col_t   position_i;
	logic               score_valid_o;
	logic               fail_o;
	logic               tetris_valid_o;
	logic [3:0]         score_o;
	dump_t              tetris_o;

	logic [5:0]  mdl [TOP+4];  // model rows, row 0 is the ground
	logic [15:0] lfsr;
	logic [3:0]  exp_score;
	logic        exp_over;
	logic        exp_end;
	dump_t       exp_dump;
	int          exp_clears;
	int          game_pieces;

	tetris_top #(.FIELD_H(FIELD_H), .GAME_ROUNDS(ROUNDS)) uut (.*);

	always #50 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string tname, input dump_t exp, input dump_t act);
		$display("** Error %s: expected %0h, actual %0h", tname, exp, act);
		$display("Something failed");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// piece shapes and random draws
	// --------------------------------------------------
	// row k of a footprint, bit 0 is the left column
	function automatic logic [3:0] foot_row(input logic [2:0] shape, input int k);
		logic [3:0] r [4];
		case (shape)
			3'd0: r = '{4'b0011, 4'b0011, 4'b0000, 4'b0000};  // square
			3'd1: r = '{4'b0001, 4'b0001, 4'b0001, 4'b0001};
			3'd2: r = '{4'b1111, 4'b0000, 4'b0000, 4'b0000};
			3'd3: r = '{4'b0010, 4'b0010, 4'b0011, 4'b0000};
			3'd4: r = '{4'b0001, 4'b0111, 4'b0000, 4'b0000};
			3'd5: r = '{4'b0011, 4'b0001, 4'b0001, 4'b0000};
			3'd6: r = '{4'b0010, 4'b0011, 4'b0001, 4'b0000};
			3'd7: r = '{4'b0011, 4'b0110, 4'b0000, 4'b0000};
		endcase
		return r[k];
	endfunction

	function automatic int piece_width(input logic [2:0] shape);
		int w;
		logic [3:0] row;
		w = 0;
		for (int k = 0; k < 4; k++) begin
			row = foot_row(shape, k);
			for (int c = 0; c < 4; c++) begin
				if (row[c] && c >= w) w = c + 1;
			end
		end
		return w;
	endfunction

	// fibonacci LFSR, taps 16 14 13 11
	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v    = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// --------------------------------------------------
	// field model
	// --------------------------------------------------
	task automatic new_game();
		for (int i = 1; i < TOP + 4; i++) mdl[i] = '0;
		mdl[0]      = 6'h3f;
		exp_score   = '0;
		game_pieces = 0;
	endtask

	task automatic model_piece(input logic [2:0] shape, input int col);
		int land;
		int low;
		logic [5:0] pr;
		land = 0;
		for (int r = 0; r < TOP; r++) begin
			for (int k = 0; k < 4; k++) begin
				pr = 6'(foot_row(shape, k)) << col;
				if ((pr & mdl[r+k]) != 0) land = r + 1;  // rests above the highest clash
			end
		end
		for (int k = 0; k < 4; k++) begin
			if (land + k <= TOP) mdl[land+k] = mdl[land+k] | (6'(foot_row(shape, k)) << col);
		end
		exp_clears = 0;
		for (int n = 0; n < FIELD_H; n++) begin
			low = 0;
			for (int i = FIELD_H; i >= 1; i--) begin
				if (mdl[i] == 6'h3f) low = i;
			end
			if (low != 0) begin
				for (int i = low; i < TOP; i++) mdl[i] = mdl[i+1];
				mdl[TOP] = '0;
				exp_clears++;
			end
		end
		exp_score   = exp_score + 4'(exp_clears);
		game_pieces = game_pieces + 1;
		exp_over    = (mdl[FIELD_H+1] != 0);
		exp_end     = exp_over || game_pieces == ROUNDS;
		exp_dump    = '0;
		if (exp_end) begin
			for (int i = 1; i <= FIELD_H; i++) exp_dump[(i-1)*6 +: 6] = mdl[i];
		end
	endtask

	// one piece in, wait for its report, compare with the model
	task automatic play_piece(input logic [2:0] shape, input int col, input string tname);
		int cycles;
		model_piece(shape, col);
		@(negedge clk);
		in_valid_i  = 1'b1;
		tetromino_i = tetris_pkg::shape_t'(shape);
		position_i  = 3'(col);
		@(negedge clk);
		in_valid_i = 1'b0;
		cycles     = 1;
		while (!score_valid_o) begin
			if (cycles > 4 * FIELD_H) abort_run({tname, ": no score_valid_o after the piece"});
			@(negedge clk);
			cycles++;
		end
		assert (cycles == 3 + exp_clears)
			else report_mismatch({tname, " latency"}, dump_t'(3 + exp_clears), dump_t'(cycles));
		assert (score_o == exp_score)
			else report_mismatch({tname, " score"}, dump_t'(exp_score), dump_t'(score_o));
		assert (fail_o == exp_over)
			else report_mismatch({tname, " fail"}, dump_t'(exp_over), dump_t'(fail_o));
		assert (tetris_valid_o == exp_end)
			else report_mismatch({tname, " game end"}, dump_t'(exp_end), dump_t'(tetris_valid_o));
		assert (tetris_o == exp_dump)
			else report_mismatch({tname, " field dump"}, exp_dump, tetris_o);
		if (exp_end) new_game();
	endtask

	always @(negedge clk) begin
		if (uut.u_sva.err_cnt != 0) abort_run("a bound assertion on tetris_top failed");
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		int shape;
		int col;
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid_i  = 1'b0;
		tetromino_i = tetris_pkg::sq;
		position_i  = '0;
		lfsr        = 16'd14658;
		new_game();
		for (int i = 0; i < 16; i++) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			assert (!score_valid_o && !fail_o && !tetris_valid_o && score_o == 4'd0
				&& tetris_o == '0) else abort_run("an output is active before any piece");
		end

		// line plus square completes row 1
		play_piece(3'd2, 0, "directed line");
		play_piece(3'd0, 4, "directed square");
		assert (score_o == 4'd1) else report_mismatch("directed clear", 1, dump_t'(score_o));

		// random pieces, run on to a game boundary
		for (int n = 0; n < 48 || game_pieces != 0; n++) begin
			draw_bits(3, shape);
			draw_bits(3, col);
			play_piece(3'(shape), col % (7 - piece_width(3'(shape))), "random");
		end

		for (int n = 0; n < 4; n++) play_piece(3'd1, 2, "stack");
		assert (fail_o && tetris_valid_o) else abort_run("the stacked lines did not fail the game");

		// fresh game, never reaches the ceiling
		for (int n = 0; n < ROUNDS; n++) begin
			if (n % 2 == 0) play_piece(3'd2, 0, "full game line");
			else play_piece(3'd0, 4, "full game square");
		end
		assert (tetris_valid_o && !fail_o) else abort_run("the last piece did not end the game");

		if (uut.u_sva.err_cnt == 0) begin
			$display("Everything OK");
			$finish;
		end
		else begin
			abort_run("a bound assertion on tetris_top failed");
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/tetris_pkg.sv
rtl/drop_solver.sv
rtl/playfield.sv
rtl/game_ctrl.sv
rtl/tetris_top.sv
sim/tetris_sva.sv
sim/tetris_tb.sv

// ==== Makefile ====
# Verilator build and run of the tetris testbench

VERILATOR ?= verilator
TOP       ?= tetris_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
